//--- verilog/t02_pkg.sv
// rv32i integer subset only: no loads, stores, branches or multiply; result_t carries no pc
package t02_pkg;

    // data and instruction word
    typedef logic [31:0] word_t;
    // register index, x0 to x31
    typedef logic [4:0]  reg_idx_t;
    // alu operation select
    typedef logic [3:0]  alu_op_t;
    // instruction fields
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // architectural register count
    localparam int NUM_REGS = 32;

    // alu operation codes
    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    // lui, immediate straight through
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // major opcodes
    localparam opcode_t OP_REG = 7'b0110011;
    localparam opcode_t OP_IMM = 7'b0010011;
    localparam opcode_t OP_LUI = 7'b0110111;

    // funct3 values, shared by r-type and i-type
    localparam funct3_t F3_ADD  = 3'b000;
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    // funct7 values, alt selects sub and sra
    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;

    // control word out of the decoder
    typedef struct packed {
        alu_op_t  alu_op;
        reg_idx_t rs1;
        reg_idx_t rs2;
        reg_idx_t rd;
        word_t    imm;
        logic     use_imm;
        logic     reg_write;
        logic     illegal;
    } decoded_t;

    // retired result
    typedef struct packed {
        reg_idx_t rd;
        word_t    value;
        logic     illegal;
    } result_t;

endpackage

//--- verilog/t02_decoder.sv
// combinational decode of r-type, i-type alu and lui only; every other encoding raises illegal
`timescale 1ns/1ps

module t02_decoder (
    input  t02_pkg::word_t    instr,
    output t02_pkg::decoded_t decoded
);

    import t02_pkg::*;

    // raw instruction fields
    opcode_t  opcode;
    funct3_t  funct3;
    funct7_t  funct7;
    word_t    imm_i;
    word_t    imm_u;
    logic     bad;
    alu_op_t  op;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // sign-extended i immediate
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    // upper immediate, low 12 bits zero
    assign imm_u = {instr[31:12], 12'b0};

    always_comb begin
        // defaults for r-type
        op                = ALU_ADD;
        bad               = 1'b0;
        decoded.rs1       = instr[19:15];
        decoded.rs2       = instr[24:20];
        decoded.rd        = instr[11:7];
        decoded.imm       = imm_i;
        decoded.use_imm   = 1'b0;

        case (opcode)
            OP_REG: begin
                case (funct3)
                    F3_ADD: begin
                        // funct7 picks add or sub
                        if (funct7 == F7_ALT) begin
                            op = ALU_SUB;
                        end else begin
                            op  = ALU_ADD;
                            bad = (funct7 != F7_BASE);
                        end
                    end
                    F3_SR: begin
                        if (funct7 == F7_ALT) begin
                            op = ALU_SRA;
                        end else begin
                            op  = ALU_SRL;
                            bad = (funct7 != F7_BASE);
                        end
                    end
                    default: begin
                        // remaining ops need funct7 zero
                        bad = (funct7 != F7_BASE);
                        case (funct3)
                            F3_SLL:  op = ALU_SLL;
                            F3_SLT:  op = ALU_SLT;
                            F3_SLTU: op = ALU_SLTU;
                            F3_XOR:  op = ALU_XOR;
                            F3_OR:   op = ALU_OR;
                            default: op = ALU_AND;
                        endcase
                    end
                endcase
            end
            OP_IMM: begin
                decoded.use_imm = 1'b1;
                case (funct3)
                    F3_ADD:  op = ALU_ADD;
                    F3_SLT:  op = ALU_SLT;
                    F3_SLTU: op = ALU_SLTU;
                    F3_XOR:  op = ALU_XOR;
                    F3_OR:   op = ALU_OR;
                    F3_AND:  op = ALU_AND;
                    F3_SLL: begin
                        // shamt in imm[4:0]
                        op  = ALU_SLL;
                        bad = (funct7 != F7_BASE);
                    end
                    default: begin
                        // srli or srai
                        if (funct7 == F7_ALT) begin
                            op = ALU_SRA;
                        end else begin
                            op  = ALU_SRL;
                            bad = (funct7 != F7_BASE);
                        end
                    end
                endcase
            end
            OP_LUI: begin
                // rs1 forced to x0, value comes from b
                op              = ALU_PASS_B;
                decoded.rs1     = '0;
                decoded.imm     = imm_u;
                decoded.use_imm = 1'b1;
            end
            default: begin
                // unknown major opcode
                bad = 1'b1;
            end
        endcase

        decoded.alu_op    = op;
        decoded.illegal   = bad;
        // illegal never writes back
        decoded.reg_write = ~bad;
    end

endmodule

//--- verilog/t02_register_file.sv
// 32 x 32-bit registers; write needs en, reg_write and a nonzero index; x0 always reads zero
`timescale 1ns/1ps

module t02_register_file (
    input  logic              clk,
    input  logic              nRST,
    input  logic              en,
    input  logic              reg_write,
    input  t02_pkg::reg_idx_t write_index,
    input  t02_pkg::reg_idx_t read_index1,
    input  t02_pkg::reg_idx_t read_index2,
    input  t02_pkg::word_t    write_data,
    output t02_pkg::word_t    read_data1,
    output t02_pkg::word_t    read_data2
);

    import t02_pkg::*;

    word_t regs [NUM_REGS];
    logic  write_en;

    // x0 is never a write target
    assign write_en = en && reg_write && (write_index != '0);

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[write_index] <= write_data;
        end
    end

    // combinational read ports
    // a write shows up here only after its edge
    assign read_data1 = (read_index1 == '0) ? '0 : regs[read_index1];
    assign read_data2 = (read_index2 == '0) ? '0 : regs[read_index2];

endmodule

//--- verilog/t02_alu.sv
// combinational alu for the rv32i integer subset; shifts use b[4:0], unknown op gives zero
`timescale 1ns/1ps

module t02_alu (
    input  t02_pkg::alu_op_t op,
    input  t02_pkg::word_t   a,
    input  t02_pkg::word_t   b,
    output t02_pkg::word_t   y
);

    import t02_pkg::*;

    // shift amount from low bits of b
    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;
    word_t      sra_out;

    assign shamt = b[4:0];

    // compares for slt and sltu
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    // arithmetic right shift keeps the sign of a
    assign sra_out = word_t'($signed(a) >>> shamt);

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_SLL: begin
                y = a << shamt;
            end
            ALU_SLT: begin
                // 1 or 0
                y = {31'b0, lt_signed};
            end
            ALU_SLTU: begin
                y = {31'b0, lt_unsigned};
            end
            ALU_XOR: begin
                y = a ^ b;
            end
            ALU_SRL: begin
                y = a >> shamt;
            end
            ALU_SRA: begin
                y = sra_out;
            end
            ALU_OR: begin
                y = a | b;
            end
            ALU_AND: begin
                y = a & b;
            end
            ALU_PASS_B: begin
                // lui
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

//--- verilog/t02_result_stage.sv
// one-cycle result register; no back-pressure, result must be taken in the valid cycle
`timescale 1ns/1ps

module t02_result_stage (
    input  logic              clk,
    input  logic              nRST,
    input  logic              instr_valid,
    input  t02_pkg::decoded_t decoded,
    input  t02_pkg::word_t    value,
    output logic              result_valid,
    output t02_pkg::result_t  result
);

    import t02_pkg::*;

    // valid pulse follows the strobe by one cycle
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= instr_valid;
        end
    end

    // capture on strobe, hold otherwise
    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            result <= '0;
        end else if (instr_valid) begin
            result.rd      <= decoded.rd;
            result.value   <= value;
            result.illegal <= decoded.illegal;
        end
    end

endmodule

//--- verilog/t02_exec_core.sv
// execute slice top; accepts one instruction per strobe, no stall, result one cycle later
`timescale 1ns/1ps

module t02_exec_core (
    input  logic             clk,
    input  logic             nRST,
    input  logic             instr_valid,
    input  t02_pkg::word_t   instr,
    output logic             result_valid,
    output t02_pkg::result_t result
);

    import t02_pkg::*;

    decoded_t decoded;
    word_t    read_data1;
    word_t    read_data2;
    word_t    operand_b;
    word_t    alu_result;

    t02_decoder t02_decoder_inst (
        .instr   (instr),
        .decoded (decoded)
    );

    // write data straight from the alu
    t02_register_file t02_register_file_inst (
        .clk         (clk),
        .nRST        (nRST),
        .en          (instr_valid),
        .reg_write   (decoded.reg_write),
        .write_index (decoded.rd),
        .read_index1 (decoded.rs1),
        .read_index2 (decoded.rs2),
        .write_data  (alu_result),
        .read_data1  (read_data1),
        .read_data2  (read_data2)
    );

    // immediate or rs2
    assign operand_b = decoded.use_imm ? decoded.imm : read_data2;

    t02_alu t02_alu_inst (
        .op (decoded.alu_op),
        .a  (read_data1),
        .b  (operand_b),
        .y  (alu_result)
    );

    t02_result_stage t02_result_stage_inst (
        .clk          (clk),
        .nRST         (nRST),
        .instr_valid  (instr_valid),
        .decoded      (decoded),
        .value        (alu_result),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

//--- verification/t02_exec_core_checker.sv
// concurrent checks on pulse timing, reset values and x0 reads; bound into t02_exec_core
`timescale 1ns/1ps

module t02_exec_core_checker (
    input logic              clk,
    input logic              nRST,
    input logic              instr_valid,
    input logic              result_valid,
    input t02_pkg::result_t  result,
    input t02_pkg::decoded_t decoded,
    input t02_pkg::word_t    read_data1,
    input t02_pkg::word_t    read_data2
);

    import t02_pkg::*;

    // failed assertions so far, read at the end of the run
    int unsigned fail_count = 0;

    // output side cleared while reset is held
    reset_clears: assert property (@(posedge clk) !nRST |=> (!result_valid && result == '0))
        else begin
            fail_count++;
            $error("result side not cleared during reset");
        end

    // one pulse per strobe, exactly one cycle later
    strobe_pulse: assert property (@(posedge clk) disable iff (!nRST)
        instr_valid |=> result_valid)
        else begin
            fail_count++;
            $error("strobe not followed by result_valid");
        end

    no_strobe_no_pulse: assert property (@(posedge clk) disable iff (!nRST)
        !instr_valid |=> !result_valid)
        else begin
            fail_count++;
            $error("result_valid without a strobe the cycle before");
        end

    // result holds between strobes
    result_held: assert property (@(posedge clk) disable iff (!nRST)
        !instr_valid |=> $stable(result))
        else begin
            fail_count++;
            $error("result changed without a strobe");
        end

    // x0 reads zero on both ports
    x0_port1: assert property (@(posedge clk) disable iff (!nRST)
        decoded.rs1 == '0 |-> read_data1 == word_t'(0))
        else begin
            fail_count++;
            $error("x0 read nonzero on port 1");
        end

    x0_port2: assert property (@(posedge clk) disable iff (!nRST)
        decoded.rs2 == '0 |-> read_data2 == word_t'(0))
        else begin
            fail_count++;
            $error("x0 read nonzero on port 2");
        end

endmodule

//--- verification/t02_exec_core_tb.sv
// self-checking testbench for the execute slice; needs the bound checker and timing support
`timescale 1ns/1ps

module t02_exec_core_tb;

    import t02_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 16;
    localparam int NUM_RANDOM      = 200;
    // loads at most 62, three readbacks, random ops, x0 and illegal groups
    localparam int PLANNED_INSTRS  = 2 * 31 + 3 * 31 + NUM_RANDOM + 4 + 6;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 20 * PLANNED_INSTRS;

    logic    clk = 1'b0;
    logic    nRST;
    logic    instr_valid;
    word_t   instr;
    logic    result_valid;
    result_t result;

    integer  seed = 32'h40f7_4b3f;
    // architectural register model, x0 never written
    word_t   model [NUM_REGS];
    // one entry per accepted instruction, oldest first
    result_t expect_q [$];

    t02_exec_core t02_exec_core_inst (
        .clk          (clk),
        .nRST         (nRST),
        .instr_valid  (instr_valid),
        .instr        (instr),
        .result_valid (result_valid),
        .result       (result)
    );

    bind t02_exec_core t02_exec_core_checker t02_exec_core_checker_inst (
        .clk          (clk),
        .nRST         (nRST),
        .instr_valid  (instr_valid),
        .result_valid (result_valid),
        .result       (result),
        .decoded      (decoded),
        .read_data1   (read_data1),
        .read_data2   (read_data2)
    );

    initial begin : clock_gen
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_on_failure(input string line);
        $display("%s", line);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first failing check");
    endtask

    // instruction encoders
    function automatic word_t r_type_word(input logic [6:0] f7, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3,
                                          input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t i_type_word(input logic [11:0] imm, input reg_idx_t rs1,
                                          input logic [2:0] f3, input reg_idx_t rd);
        return {imm, rs1, f3, rd, OP_IMM};
    endfunction

    function automatic word_t lui_word(input logic [19:0] imm, input reg_idx_t rd);
        return {imm, rd, OP_LUI};
    endfunction

    // rv32i semantics keyed by funct3
    function automatic word_t rv32i_op(input logic [2:0] f3, input logic alt,
                                       input word_t a, input word_t b);
        word_t      y;
        logic [4:0] sh;
        sh = b[4:0];
        case (f3)
            3'b000: y = alt ? a - b : a + b;
            3'b001: y = a << sh;
            // differing signs decide a signed compare on their own
            3'b010: y = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            3'b011: y = {31'b0, a < b};
            3'b100: y = a ^ b;
            // sra refills the top bits with the sign
            3'b101: y = (a >> sh) | ((alt && a[31]) ? ~(32'hffff_ffff >> sh) : 32'h0);
            3'b110: y = a | b;
            default: y = a & b;
        endcase
        return y;
    endfunction

    task automatic send_instr(input word_t word, input word_t value, input logic illegal);
        result_t want;
        want.rd      = word[11:7];
        want.value   = value;
        want.illegal = illegal;
        @(negedge clk);
        instr_valid = 1'b1;
        instr       = word;
        expect_q.push_back(want);
        // later instructions see this write
        if (!illegal && want.rd != '0) begin
            model[want.rd] = value;
        end
    endtask

    task automatic exec_r(input logic [2:0] f3, input logic alt, input reg_idx_t rs1,
                          input reg_idx_t rs2, input reg_idx_t rd);
        word_t value;
        value = rv32i_op(f3, alt, model[rs1], model[rs2]);
        send_instr(r_type_word(alt ? 7'b0100000 : 7'b0000000, rs2, rs1, f3, rd), value, 1'b0);
    endtask

    task automatic exec_i(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rd,
                          input logic [11:0] imm);
        word_t value;
        logic  alt;
        // only srai uses imm[10] as a mode bit
        alt   = (f3 == 3'b101) && imm[10];
        value = rv32i_op(f3, alt, model[rs1], {{20{imm[11]}}, imm});
        send_instr(i_type_word(imm, rs1, f3, rd), value, 1'b0);
    endtask

    task automatic exec_lui(input reg_idx_t rd, input logic [19:0] imm);
        send_instr(lui_word(imm, rd), {imm, 12'h000}, 1'b0);
    endtask

    task automatic idle_cycles(input int n);
        word_t junk;
        for (int k = 0; k < n; k++) begin
            junk = $random(seed);
            @(negedge clk);
            instr_valid = 1'b0;
            // junk alternates with an addi that would write if it were accepted
            instr = k[0] ? junk : i_type_word(junk[31:20], junk[19:15], 3'b000,
                                              junk[11:7] | 5'd1);
        end
    endtask

    task automatic load_registers();
        word_t       r;
        logic [19:0] hi;
        for (int i = 1; i < NUM_REGS; i++) begin
            r = $random(seed);
            if (i % 4 == 0) begin
                // sign-extended 12-bit value from x0
                exec_i(3'b000, 5'd0, reg_idx_t'(i), r[11:0]);
            end else begin
                // round the upper part since addi sign-extends
                hi = r[31:12] + {19'b0, r[11]};
                exec_lui(reg_idx_t'(i), hi);
                exec_i(3'b000, reg_idx_t'(i), reg_idx_t'(i), r[11:0]);
            end
        end
        idle_cycles(2);
    endtask

    task automatic read_back_all();
        for (int i = 1; i < NUM_REGS; i++) begin
            // alternate the two read ports
            if (i % 2 == 1) begin
                exec_r(3'b000, 1'b0, reg_idx_t'(i), 5'd0, reg_idx_t'(i));
            end else begin
                exec_r(3'b000, 1'b0, 5'd0, reg_idx_t'(i), reg_idx_t'(i));
            end
        end
        idle_cycles(1);
    endtask

    task automatic random_ops();
        word_t       r;
        word_t       c;
        logic [2:0]  f3;
        logic        alt;
        reg_idx_t    rs1;
        reg_idx_t    rd;
        reg_idx_t    last_rd;
        logic [11:0] imm;
        last_rd = 5'd1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r   = $random(seed);
            c   = $random(seed);
            f3  = r[2:0];
            rd  = r[7:3];
            // about half chain on the previous destination
            rs1 = c[2] ? last_rd : r[12:8];
            alt = c[1] && (f3 == 3'b000 || f3 == 3'b101);
            if (c[4:3] == 2'b00) begin
                idle_cycles(1);
            end
            if (c[0]) begin
                imm = r[31:20];
                if (f3 == 3'b001 || f3 == 3'b101) begin
                    // shamt form
                    imm = {1'b0, alt && f3 == 3'b101, 5'b0, r[24:20]};
                end
                exec_i(f3, rs1, rd, imm);
            end else begin
                exec_r(f3, alt, rs1, r[17:13], rd);
            end
            last_rd = rd;
        end
        idle_cycles(2);
    endtask

    task automatic x0_writes();
        exec_i(3'b000, 5'd5, 5'd0, 12'h123);
        exec_r(3'b110, 1'b0, 5'd6, 5'd7, 5'd0);
        // x0 still zero on both ports
        exec_r(3'b000, 1'b0, 5'd0, 5'd0, 5'd9);
        exec_i(3'b110, 5'd0, 5'd10, 12'h000);
        idle_cycles(1);
    endtask

    task automatic illegal_ops();
        // load opcode
        send_instr({12'h004, 5'd1, 3'b010, 5'd3, 7'b0000011}, '0, 1'b1);
        // multiply funct7
        send_instr(r_type_word(7'b0000001, 5'd2, 5'd1, 3'b000, 5'd4), '0, 1'b1);
        send_instr(r_type_word(7'b0100000, 5'd2, 5'd1, 3'b100, 5'd5), '0, 1'b1);
        // shift immediates with a bad upper field
        send_instr(i_type_word({7'b0100000, 5'd3}, 5'd1, 3'b001, 5'd6), '0, 1'b1);
        send_instr(i_type_word({7'b0000001, 5'd2}, 5'd1, 3'b101, 5'd7), '0, 1'b1);
        send_instr(32'hffff_ffff, '0, 1'b1);
        idle_cycles(1);
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin : check_results
        result_t want;
        // checker failures stop the run at the next falling edge
        assert (t02_exec_core_inst.t02_exec_core_checker_inst.fail_count == 0)
            else stop_on_failure("a concurrent assertion in the bound checker failed");
        if (result_valid) begin
            assert (expect_q.size() > 0)
                else stop_on_failure("result_valid pulsed with no instruction outstanding");
            want = expect_q.pop_front();
            assert (result.rd == want.rd)
                else stop_on_failure($sformatf("error %0d ns: rd %0d, expected %0d",
                                               $time, result.rd, want.rd));
            assert (result.illegal == want.illegal)
                else stop_on_failure($sformatf("error %0d ns: illegal %0b, expected %0b",
                                               $time, result.illegal, want.illegal));
            // value of an illegal encoding is not defined
            assert (want.illegal || result.value == want.value)
                else stop_on_failure($sformatf("error %0d ns: x%0d value %08h, expected %08h",
                                               $time, want.rd, result.value, want.value));
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        nRST        = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        foreach (model[i]) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(negedge clk);
        nRST = 1'b1;
        idle_cycles(2);
        load_registers();
        read_back_all();
        random_ops();
        read_back_all();
        x0_writes();
        illegal_ops();
        idle_cycles(6);
        read_back_all();
        idle_cycles(3);
        if (expect_q.size() != 0 ||
            t02_exec_core_inst.t02_exec_core_checker_inst.fail_count != 0) begin
            $display("%0d results never arrived or a checker assertion failed", expect_q.size());
            $display("STATUS: FAIL");
            $fatal(1, "run ended with failures");
        end else begin
            $display("STATUS: PASS");
            $finish;
        end
    end

endmodule

//--- tb.f
verilog/t02_pkg.sv
verilog/t02_decoder.sv
verilog/t02_register_file.sv
verilog/t02_alu.sv
verilog/t02_result_stage.sv
verilog/t02_exec_core.sv
verification/t02_exec_core_checker.sv
verification/t02_exec_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module t02_exec_core_tb \
    -Mdir obj_dir -o sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim > sim.log 2>&1 || echo "STATUS: FAIL" >> sim.log
cat sim.log
grep -q "STATUS: FAIL" sim.log \
    && { echo "simulation failed"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
